/* alu/aluUnit.sv */
// Multi-cycle ALU with one-step logic, add and shift operations, shift-add multiplier and Z
`default_nettype none

module aluUnit (
   input  logic             Clock,
   input  logic             reset,
   input  logic             start,
   input  aluPkg::aluOp     opSelect,
   input  datapathPkg::word y,
   input  datapathPkg::word bus,
   output logic             finished,
   output datapathPkg::word zLow,
   output datapathPkg::word zHigh
);
   import datapathPkg::*;
   import aluPkg::*;

   aluState                      state;
   word                          result;
   word                          multiplicand;
   logic [2*WordWidth-1:0]       product;
   logic [WordWidth:0]           partialSum;
   logic [$clog2(MulSteps)-1:0]  stepCount;
   logic                         accept;

   // New requests are taken only while idle
   assign accept   = (state == AluIdle) && start;
   assign finished = (state == AluDone);

   // Y is operand A, the bus operand B; negate and invert act on B
   always_comb begin
      unique case (opSelect)
         OpAdd:   result = y + bus;
         OpSub:   result = y - bus;
         OpAnd:   result = y & bus;
         OpOr:    result = y | bus;
         OpShr:   result = y >> bus[ShiftWidth-1:0];
         OpShl:   result = y << bus[ShiftWidth-1:0];
         OpNeg:   result = -bus;
         OpNot:   result = ~bus;
         default: result = '0;
      endcase
   end

   // Upper half plus the multiplicand when the current multiplier bit is set
   assign partialSum = {1'b0, product[2*WordWidth-1:WordWidth]}
                     + (product[0] ? {1'b0, multiplicand} : '0);

   always_ff @(posedge Clock) begin
      if (reset) begin
         state     <= AluIdle;
         stepCount <= '0;
         zLow      <= '0;
         zHigh     <= '0;
      end else begin
         unique case (state)
            AluIdle: begin
               if (accept) begin
                  if (opSelect == OpMul) begin
                     stepCount <= '0;
                     state     <= AluMultiply;
                  end else begin
                     zLow  <= result;
                     zHigh <= '0;
                     state <= AluDone;
                  end
               end
            end
            AluMultiply: begin
               stepCount <= stepCount + 1'b1;
               // Last step goes straight into Z
               if (stepCount == ($clog2(MulSteps))'(MulSteps - 1)) begin
                  zLow  <= {partialSum[0], product[WordWidth-1:1]};
                  zHigh <= partialSum[WordWidth:1];
                  state <= AluDone;
               end
            end
            AluDone: begin
               state <= AluIdle;
            end
            default: begin
               state <= AluIdle;
            end
         endcase
      end
   end

   // Multiplier starts in the low half and shifts out as the product shifts in
   always_ff @(posedge Clock) begin
      if (accept) begin
         multiplicand <= y;
         product      <= {{WordWidth{1'b0}}, bus};
      end else if (state == AluMultiply) begin
         product <= {partialSum, product[WordWidth-1:1]};
      end
   end

endmodule

`default_nettype wire

/* common/aluPkg.sv */
// ALU operation codes, shift and multiply step constants, ALU sequencer states
`default_nettype none

package aluPkg;

   // Shift amount comes from the low bits of the bus
   localparam int ShiftWidth = 5;

   // One shift-add step per multiplier bit
   localparam int MulSteps = 32;

   // Codes run in sequence from OpAdd to OpMul
   typedef enum logic [4:0] {
      OpAdd = 5'b00100,
      OpSub = 5'b00101,
      OpAnd = 5'b00110,
      OpOr  = 5'b00111,
      OpShr = 5'b01000,
      OpShl = 5'b01001,
      OpNeg = 5'b01010,
      OpNot = 5'b01011,
      OpMul = 5'b01100
   } aluOp;

   typedef enum logic [1:0] {
      AluIdle,
      AluMultiply,
      AluDone
   } aluState;

endpackage

`default_nettype wire

/* common/datapathPkg.sv */
// Word, register index and memory address types, IR field positions and memory sizing
`default_nettype none

package datapathPkg;

   // Data path width shared by the bus, registers and memory
   localparam int WordWidth = 32;

   // Sixteen general purpose registers
   localparam int RegisterCount = 16;

   // Memory holds this many words
   localparam int MemoryDepth = 256;

   // Register fields of the instruction word
   localparam int RaHigh = 26;
   localparam int RaLow  = 23;
   localparam int RbHigh = 22;
   localparam int RbLow  = 19;
   localparam int RcHigh = 18;
   localparam int RcLow  = 15;

   // Immediate in the low bits, sign-extended onto the bus
   localparam int ImmediateWidth = 19;

   typedef logic [WordWidth-1:0] word;

   typedef logic [$clog2(RegisterCount)-1:0] regIndex;

   // Low bits of MAR
   typedef logic [$clog2(MemoryDepth)-1:0] memAddress;

endpackage

`default_nettype wire

/* compile.f */
common/datapathPkg.sv
common/aluPkg.sv
src/registerFile.sv
src/busRegisters.sv
alu/aluUnit.sv
memory/memoryUnit.sv
src/dataPath.sv
tests/dataPath_assert.sv
tests/dataPathTb.sv

/* memory/memoryUnit.sv */
// MAR, MDR, synchronous word memory and the read/write sequencer with memFinished
`default_nettype none

module memoryUnit (
   input  logic             Clock,
   input  logic             reset,
   input  datapathPkg::word bus,
   input  logic             marLoad,
   input  logic             mdrLoad,
   input  logic             read,
   input  logic             write,
   output datapathPkg::word mdr,
   output logic             memFinished
);
   import datapathPkg::*;

   typedef enum logic [2:0] {
      MemIdle,
      MemRead,
      MemWrite,
      MemDone,
      MemRelease
   } memState;

   memState   state;
   word       mar;
   word       memory [MemoryDepth];
   memAddress address;
   logic      readStart;
   logic      writeStart;

   assign address     = mar[$bits(memAddress)-1:0];
   assign readStart   = (state == MemIdle) && read && mdrLoad;
   assign writeStart  = (state == MemIdle) && write && !readStart;
   assign memFinished = (state == MemDone);

   always_ff @(posedge Clock) begin
      if (reset) begin
         state <= MemIdle;
         mar   <= '0;
         mdr   <= '0;
      end else begin
         if (marLoad) mar <= bus;
         // Read data lands in MDR on the second edge
         if (state == MemRead) begin
            mdr <= memory[address];
         end else if (mdrLoad && !read) begin
            mdr <= bus;
         end
         unique case (state)
            MemIdle: begin
               if (readStart) begin
                  state <= MemRead;
               end else if (writeStart) begin
                  state <= MemWrite;
               end
            end
            MemRead:    state <= MemDone;
            MemWrite:   state <= MemDone;
            MemDone:    state <= MemRelease;
            // Hold until the controller drops both requests
            MemRelease: if (!read && !write) state <= MemIdle;
            default:    state <= MemIdle;
         endcase
      end
   end

   always_ff @(posedge Clock) begin
      if (writeStart) memory[address] <= mdr;
   end

endmodule

`default_nettype wire

/* src/busRegisters.sv */
// PC, IR, Y, HI, LO, input and output port registers and the bus source multiplexer
`default_nettype none

module busRegisters (
   input  logic             Clock,
   input  logic             reset,
   input  logic             pcDrive,
   input  logic             irDrive,
   input  logic             zLowDrive,
   input  logic             zHighDrive,
   input  logic             hiDrive,
   input  logic             loDrive,
   input  logic             immDrive,
   input  logic             inportDrive,
   input  logic             mdrDrive,
   input  logic             rOut,
   input  logic             pcLoad,
   input  logic             irLoad,
   input  logic             yLoad,
   input  logic             hiLoad,
   input  logic             loLoad,
   input  logic             outportLoad,
   input  logic             incPc,
   input  logic             deviceStrobe,
   input  datapathPkg::word deviceIn,
   input  datapathPkg::word readValue,
   input  datapathPkg::word zLow,
   input  datapathPkg::word zHigh,
   input  datapathPkg::word mdr,
   output datapathPkg::word bus,
   output datapathPkg::word ir,
   output datapathPkg::word y,
   output datapathPkg::word deviceOut
);
   import datapathPkg::*;

   word pc;
   word hi;
   word lo;
   word inport;
   word immediate;

   assign immediate = {{(WordWidth-ImmediateWidth){ir[ImmediateWidth-1]}},
                       ir[ImmediateWidth-1:0]};

   always_ff @(posedge Clock) begin
      if (reset) begin
         pc        <= '0;
         ir        <= '0;
         y         <= '0;
         hi        <= '0;
         lo        <= '0;
         inport    <= '0;
         deviceOut <= '0;
      end else begin
         // A bus load takes priority over the increment
         if (pcLoad) begin
            pc <= bus;
         end else if (incPc) begin
            pc <= pc + 1'b1;
         end
         if (irLoad)       ir        <= bus;
         if (yLoad)        y         <= bus;
         if (hiLoad)       hi        <= bus;
         if (loLoad)       lo        <= bus;
         if (outportLoad)  deviceOut <= bus;
         if (deviceStrobe) inport    <= deviceIn;
      end
   end

   // Only one drive strobe is high at a time; the bus idles at zero
   always_comb begin
      unique case (1'b1)
         pcDrive:     bus = pc;
         irDrive:     bus = ir;
         zLowDrive:   bus = zLow;
         zHighDrive:  bus = zHigh;
         hiDrive:     bus = hi;
         loDrive:     bus = lo;
         immDrive:    bus = immediate;
         inportDrive: bus = inport;
         mdrDrive:    bus = mdr;
         rOut:        bus = readValue;
         default:     bus = '0;
      endcase
   end

endmodule

`default_nettype wire

/* src/dataPath.sv */
// Single-bus CPU datapath top: bus, register blocks, ALU and memory
`default_nettype none

module dataPath (
   input  logic             Clock,
   input  logic             reset,
   input  logic             pcDrive,
   input  logic             irDrive,
   input  logic             zLowDrive,
   input  logic             zHighDrive,
   input  logic             hiDrive,
   input  logic             loDrive,
   input  logic             immDrive,
   input  logic             inportDrive,
   input  logic             mdrDrive,
   input  logic             rOut,
   input  logic             pcLoad,
   input  logic             irLoad,
   input  logic             yLoad,
   input  logic             hiLoad,
   input  logic             loLoad,
   input  logic             marLoad,
   input  logic             outportLoad,
   input  logic             rIn,
   input  logic             incPc,
   input  logic             gra,
   input  logic             grb,
   input  logic             grc,
   input  logic             baOut,
   input  aluPkg::aluOp     opSelect,
   input  logic             start,
   input  logic             read,
   input  logic             write,
   input  logic             mdrLoad,
   input  logic             deviceStrobe,
   input  datapathPkg::word deviceIn,
   output logic             finished,
   output logic             memFinished,
   output datapathPkg::word deviceOut
);
   import datapathPkg::*;

   word bus;
   word ir;
   word y;
   word readValue;
   word zLow;
   word zHigh;
   word mdr;

   registerFile u_registerFile (
      .Clock, .reset, .ir, .bus, .gra, .grb, .grc, .rIn, .rOut, .baOut, .readValue
   );

   // Owns the bus multiplexer
   busRegisters u_busRegisters (
      .Clock, .reset, .pcDrive, .irDrive, .zLowDrive, .zHighDrive, .hiDrive, .loDrive,
      .immDrive, .inportDrive, .mdrDrive, .rOut, .pcLoad, .irLoad, .yLoad, .hiLoad,
      .loLoad, .outportLoad, .incPc, .deviceStrobe, .deviceIn, .readValue, .zLow,
      .zHigh, .mdr, .bus, .ir, .y, .deviceOut
   );

   aluUnit u_alu (
      .Clock, .reset, .start, .opSelect, .y, .bus, .finished, .zLow, .zHigh
   );

   memoryUnit u_memory (
      .Clock, .reset, .bus, .marLoad, .mdrLoad, .read, .write, .mdr, .memFinished
   );

endmodule

`default_nettype wire

/* src/registerFile.sv */
// General register file with Gra/Grb/Grc field decode, BAout zeroing and bus access
`default_nettype none

module registerFile (
   input  logic             Clock,
   input  logic             reset,
   input  datapathPkg::word ir,
   input  datapathPkg::word bus,
   input  logic             gra,
   input  logic             grb,
   input  logic             grc,
   input  logic             rIn,
   input  logic             rOut,
   input  logic             baOut,
   output datapathPkg::word readValue
);
   import datapathPkg::*;

   word     registers [RegisterCount];
   regIndex index;

   // Register number from the selected IR field
   always_comb begin
      if (gra) begin
         index = ir[RaHigh:RaLow];
      end else if (grb) begin
         index = ir[RbHigh:RbLow];
      end else if (grc) begin
         index = ir[RcHigh:RcLow];
      end else begin
         index = '0;
      end
   end

   always_ff @(posedge Clock) begin
      if (reset) begin
         for (int i = 0; i < RegisterCount; i++) begin
            registers[i] <= '0;
         end
      end else if (rIn) begin
         registers[index] <= bus;
      end
   end

   // R0 reads as zero under BAout for base address arithmetic
   always_comb begin
      if (!rOut) begin
         readValue = '0;
      end else if (baOut && index == '0) begin
         readValue = '0;
      end else begin
         readValue = registers[index];
      end
   end

endmodule

`default_nettype wire

/* tests/dataPathTb.sv */
// Datapath testbench: clock, reset, control sequence tasks, directed tests and final report
`default_nettype none

module dataPathTb;
   timeunit 1ns;
   timeprecision 1ps;
   import datapathPkg::*;
   import aluPkg::*;

   localparam int TimeoutCycles = 2000;

   logic Clock, reset;
   logic pcDrive, irDrive, zLowDrive, zHighDrive, hiDrive, loDrive, immDrive;
   logic inportDrive, mdrDrive, rOut;
   logic pcLoad, irLoad, yLoad, hiLoad, loLoad, marLoad, outportLoad, rIn;
   logic incPc, gra, grb, grc, baOut, start, read, write, mdrLoad, deviceStrobe;
   logic finished, memFinished;
   aluOp opSelect;
   word  deviceIn;
   word  deviceOut;
   word  randomState = 32'd12;
   int   cycleCount = 0;

   dataPath u_dut (.*);

   initial begin
      Clock = 1'b0;
      forever #50 Clock = ~Clock;
   end

   always @(posedge Clock) begin
      cycleCount++;
      if (cycleCount > TimeoutCycles) begin
         reportFailure("timeout: the tests did not complete within the cycle limit");
      end else if (u_dut.assertChecks.failureCount != 0) begin
         reportFailure("bound assertions failed during the run");
      end
   end

   task automatic reportFailure(input string message);
      $display("%s", message);
      $display("FAIL: see errors above");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic checkValue(input string name, input word expected, input word actual);
      assert (actual === expected)
      else reportFailure($sformatf("mismatch in %s: expected %h, actual %h",
                                   name, expected, actual));
   endtask

   // Xorshift generator for operands
   function automatic word nextRandom();
      randomState = randomState ^ (randomState << 13);
      randomState = randomState ^ (randomState >> 17);
      randomState = randomState ^ (randomState << 5);
      return randomState;
   endfunction

   function automatic word modelResult(input aluOp op, input word a, input word b);
      case (op)
         OpAdd:   return a + b;
         OpSub:   return a - b;
         OpAnd:   return a & b;
         OpOr:    return a | b;
         OpShr:   return a >> b[4:0];
         OpShl:   return a << b[4:0];
         OpNeg:   return -b;
         OpNot:   return ~b;
         default: return '0;
      endcase
   endfunction

   function automatic word makeInstr(input regIndex ra, input regIndex rb, input regIndex rc);
      return {5'b0, ra, rb, rc, 15'b0};
   endfunction

   task automatic clearStrobes;
      {pcDrive, irDrive, zLowDrive, zHighDrive, hiDrive, loDrive, immDrive} = '0;
      {inportDrive, mdrDrive, rOut} = '0;
      {pcLoad, irLoad, yLoad, hiLoad, loLoad, marLoad, outportLoad, rIn} = '0;
      {incPc, gra, grb, grc, baOut, start, read, write, mdrLoad, deviceStrobe} = '0;
   endtask

   // One control state, strobes set beforehand act on the next rising edge
   task automatic step;
      @(negedge Clock);
      clearStrobes();
   endtask

   task automatic loadIr(input word instr);
      deviceIn = instr;
      deviceStrobe = 1'b1;
      step();
      inportDrive = 1'b1;
      irLoad = 1'b1;
      step();
   endtask

   task automatic loadRegister(input regIndex index, input word value);
      loadIr(makeInstr(index, 4'd0, 4'd0));
      deviceIn = value;
      deviceStrobe = 1'b1;
      step();
      inportDrive = 1'b1;
      rIn = 1'b1;
      gra = 1'b1;
      step();
   endtask

   task automatic readOut(input regIndex index, input logic useBa, output word value);
      loadIr(makeInstr(index, 4'd0, 4'd0));
      rOut = 1'b1;
      gra = 1'b1;
      baOut = useBa;
      outportLoad = 1'b1;
      step();
      value = deviceOut;
   endtask

   task automatic waitFinished(output int waited);
      waited = 0;
      while (!finished) begin
         @(negedge Clock);
         waited++;
      end
   endtask

   // Holds read or write until memFinished, then leaves the sequencer idle
   task automatic waitMemory;
      do begin
         @(negedge Clock);
      end while (!memFinished);
      read = 1'b0;
      write = 1'b0;
      mdrLoad = 1'b0;
      @(negedge Clock);
      assert (!memFinished)
      else reportFailure("memFinished stayed high for more than one cycle");
      @(negedge Clock);
   endtask

   // R2 into Y, R3 on the bus as operand B, destination field R4
   task automatic aluStep(input aluOp op, input word a, input word b, output int waited);
      loadRegister(4'd2, a);
      loadRegister(4'd3, b);
      loadIr(makeInstr(4'd4, 4'd2, 4'd3));
      rOut = 1'b1;
      grb = 1'b1;
      yLoad = 1'b1;
      step();
      rOut = 1'b1;
      grc = 1'b1;
      opSelect = op;
      start = 1'b1;
      step();
      waitFinished(waited);
   endtask

   task automatic memoryAccess(input logic isWrite, input word address, input word value,
                               output word data);
      deviceIn = address;
      deviceStrobe = 1'b1;
      step();
      inportDrive = 1'b1;
      marLoad = 1'b1;
      step();
      if (isWrite) begin
         deviceIn = value;
         deviceStrobe = 1'b1;
         step();
         inportDrive = 1'b1;
         mdrLoad = 1'b1;
         step();
         write = 1'b1;
      end else begin
         read = 1'b1;
         mdrLoad = 1'b1;
      end
      waitMemory();
      data = '0;
      if (!isWrite) begin
         loadIr(makeInstr(4'd7, 4'd0, 4'd0));
         mdrDrive = 1'b1;
         rIn = 1'b1;
         gra = 1'b1;
         step();
         readOut(4'd7, 1'b0, data);
      end
   endtask

   task automatic registerTransfer;
      word value;
      word result;
      value = nextRandom();
      loadRegister(4'd1, value);
      readOut(4'd1, 1'b0, result);
      checkValue("register transfer", value, result);
      loadRegister(4'd0, value | 32'h1);
      readOut(4'd0, 1'b0, result);
      checkValue("R0 write", value | 32'h1, result);
      readOut(4'd0, 1'b1, result);
      checkValue("R0 with baOut", '0, result);
   endtask

   task automatic singleCycleTest;
      aluOp ops [8] = '{OpAdd, OpSub, OpAnd, OpOr, OpShr, OpShl, OpNeg, OpNot};
      word  a;
      word  b;
      word  result;
      int   waited;
      for (int pair = 0; pair < 2; pair++) begin
         for (int i = 0; i < 8; i++) begin
            a = nextRandom();
            b = nextRandom();
            aluStep(ops[i], a, b, waited);
            // Finished is already up at the edge after start
            checkValue("single-cycle finished latency", 32'd0, waited);
            zLowDrive = 1'b1;
            rIn = 1'b1;
            gra = 1'b1;
            step();
            readOut(4'd4, 1'b0, result);
            checkValue(ops[i].name(), modelResult(ops[i], a, b), result);
         end
      end
   endtask

   task automatic multiplyTest;
      word         a;
      word         b;
      word         high;
      word         low;
      logic [63:0] product;
      int          waited;
      for (int pair = 0; pair < 3; pair++) begin
         a = nextRandom();
         b = nextRandom();
         product = {32'b0, a} * {32'b0, b};
         aluStep(OpMul, a, b, waited);
         assert (waited > 0)
         else reportFailure("multiply raised finished before its shift-add steps ran");
         zHighDrive = 1'b1;
         hiLoad = 1'b1;
         step();
         zLowDrive = 1'b1;
         loLoad = 1'b1;
         step();
         hiDrive = 1'b1;
         outportLoad = 1'b1;
         step();
         high = deviceOut;
         loDrive = 1'b1;
         outportLoad = 1'b1;
         step();
         low = deviceOut;
         checkValue("multiply high word", product[63:32], high);
         checkValue("multiply low word", product[31:0], low);
      end
   endtask

   task automatic memoryRoundTrip;
      word values [4];
      word data;
      for (int i = 0; i < 4; i++) begin
         values[i] = nextRandom();
         memoryAccess(1'b1, 32'(i * 37 + 5), values[i], data);
      end
      for (int i = 0; i < 4; i++) begin
         memoryAccess(1'b0, 32'(i * 37 + 5), '0, data);
         checkValue("memory round trip", values[i], data);
      end
   endtask

   // Fetch and execute of a store, ra to memory at immediate plus rb
   task automatic storeSequence;
      word            startPc;
      word            base;
      word            data;
      word            instr;
      word            address;
      word            result;
      logic [18:0]    imm;
      int             waited;
      startPc = 32'h30;
      base = 32'h140;
      imm = -19'sd12;
      data = nextRandom();
      instr = {5'b00011, 4'd5, 4'd6, imm};
      address = base + {{13{imm[18]}}, imm};
      loadRegister(4'd5, data);
      loadRegister(4'd6, base);
      memoryAccess(1'b1, startPc, instr, result);
      deviceIn = startPc;
      deviceStrobe = 1'b1;
      step();
      inportDrive = 1'b1;
      pcLoad = 1'b1;
      step();
      pcDrive = 1'b1;
      marLoad = 1'b1;
      incPc = 1'b1;
      step();
      read = 1'b1;
      mdrLoad = 1'b1;
      waitMemory();
      mdrDrive = 1'b1;
      irLoad = 1'b1;
      step();
      grb = 1'b1;
      baOut = 1'b1;
      rOut = 1'b1;
      yLoad = 1'b1;
      step();
      immDrive = 1'b1;
      opSelect = OpAdd;
      start = 1'b1;
      step();
      waitFinished(waited);
      zLowDrive = 1'b1;
      marLoad = 1'b1;
      step();
      gra = 1'b1;
      rOut = 1'b1;
      mdrLoad = 1'b1;
      step();
      write = 1'b1;
      waitMemory();
      pcDrive = 1'b1;
      outportLoad = 1'b1;
      step();
      checkValue("PC after fetch", startPc + 1, deviceOut);
      memoryAccess(1'b0, address, '0, result);
      checkValue("store readback", data, result);
   endtask

   initial begin
      reset = 1'b1;
      clearStrobes();
      deviceIn = '0;
      opSelect = OpAdd;
      repeat (8) @(negedge Clock);
      reset = 1'b0;
      registerTransfer();
      singleCycleTest();
      multiplyTest();
      memoryRoundTrip();
      storeSequence();
      @(negedge Clock);
      if (u_dut.assertChecks.failureCount == 0) begin
         $display("PASS: all tests");
         $finish;
      end else begin
         reportFailure("bound assertions failed during the run");
      end
   end

endmodule

`default_nettype wire

/* tests/dataPath_assert.sv */
// Bound checks on bus drive ownership and on the ALU and memory finished pulses
`default_nettype none

module dataPathAssert (
   input logic Clock,
   input logic reset,
   input logic pcDrive,
   input logic irDrive,
   input logic zLowDrive,
   input logic zHighDrive,
   input logic hiDrive,
   input logic loDrive,
   input logic immDrive,
   input logic inportDrive,
   input logic mdrDrive,
   input logic rOut,
   input logic start,
   input logic finished,
   input logic read,
   input logic write,
   input logic memFinished
);
   timeunit 1ns;
   timeprecision 1ps;

   int   failureCount = 0;
   logic aluPending;

   // Open ALU request between start and finished
   always_ff @(posedge Clock) begin
      if (reset) begin
         aluPending <= 1'b0;
      end else if (start) begin
         aluPending <= 1'b1;
      end else if (finished) begin
         aluPending <= 1'b0;
      end
   end

   singleDriver: assert property (@(posedge Clock) disable iff (reset)
      $onehot0({pcDrive, irDrive, zLowDrive, zHighDrive, hiDrive, loDrive, immDrive,
                inportDrive, mdrDrive, rOut}))
   else begin
      $error("more than one source drives the bus");
      failureCount++;
   end

   finishedPulse: assert property (@(posedge Clock) disable iff (reset)
      finished |=> !finished)
   else begin
      $error("finished is high for more than one cycle");
      failureCount++;
   end

   finishedAfterStart: assert property (@(posedge Clock) disable iff (reset)
      finished |-> aluPending)
   else begin
      $error("finished is raised without a preceding start");
      failureCount++;
   end

   memoryResponse: assert property (@(posedge Clock) disable iff (reset)
      ($rose(read) || $rose(write)) |-> ##[1:2] memFinished)
   else begin
      $error("memFinished is missing within two cycles of a request");
      failureCount++;
   end

endmodule

bind dataPath dataPathAssert assertChecks (.*);

`default_nettype wire
